/* lpif_txrx_x8.f */
hw/lpif_link_pkg.sv
hw/lpif_phy_pkg.sv
hw/lpif_online_sync.sv
hw/lpif_flit_codec.sv
hw/lpif_lane_slicer.sv
hw/lpif_phy_lane.sv
hw/lpif_lane_merger.sv
hw/lpif_txrx_x8_top.sv
bench/lpif_txrx_x8_tb.sv

/* Bender.yml */
package:
  name: lpif_txrx_x8

sources:
  # Packages first, then RTL bottom-up
  - files:
      - hw/lpif_link_pkg.sv
      - hw/lpif_phy_pkg.sv
      - hw/lpif_online_sync.sv
      - hw/lpif_flit_codec.sv
      - hw/lpif_lane_slicer.sv
      - hw/lpif_phy_lane.sv
      - hw/lpif_lane_merger.sv
      - hw/lpif_txrx_x8_top.sv

  - target: simulation
    files:
      - bench/lpif_txrx_x8_tb.sv

/* bench/lpif_txrx_x8_tb.sv */
// Loopback testbench for the eight-lane link layer top; compile with the project file list
module lpif_txrx_x8_tb
  import lpif_link_pkg::*;
  import lpif_phy_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // Run constants
  ////////////////////////////////////////

  // Online delays in cycles
  localparam int tx_delay   = 10;
  localparam int rx_delay   = 20;
  // Strobe lag is the delay plus load edge and lane register
  localparam int strobe_lag = tx_delay + 2;
  // dstrm to ustrm through codec, both lane registers and merger
  localparam int loop_lat   = 4;
  // About 300 cycles of traffic with wide margin
  localparam int max_cycles = 2000;
  localparam int show_w     = num_lanes * lane_w;
  localparam int lane_sel_w = $clog2(num_lanes);

  // One expected ustrm beat due on a given cycle
  typedef struct packed {
    int                  due;
    logic                ok;
    logic                valid;
    logic                dvalid;
    logic                crc_valid;
    logic [state_w-1:0]  state;
    logic [protid_w-1:0] protid;
    logic [data_w-1:0]   data;
    logic [crc_w-1:0]    crc;
    logic [dbg_w-1:0]    rx_err;
  } model_flit_t;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic                             clk_wr;
  logic                             rst_n;
  logic                             tx_online;
  logic                             rx_online;
  logic [15:0]                      delay_x_value;
  logic [15:0]                      delay_y_value;
  logic [num_lanes-1:0][lane_w-1:0] tx_phy;
  logic [num_lanes-1:0][lane_w-1:0] rx_phy;
  logic [state_w-1:0]               dstrm_state;
  logic [protid_w-1:0]              dstrm_protid;
  logic [data_w-1:0]                dstrm_data;
  logic                             dstrm_dvalid;
  logic [crc_w-1:0]                 dstrm_crc;
  logic                             dstrm_crc_valid;
  logic                             dstrm_valid;
  logic [state_w-1:0]               ustrm_state;
  logic [protid_w-1:0]              ustrm_protid;
  logic [data_w-1:0]                ustrm_data;
  logic                             ustrm_dvalid;
  logic [crc_w-1:0]                 ustrm_crc;
  logic                             ustrm_crc_valid;
  logic                             ustrm_valid;
  logic [dbg_w-1:0]                 tx_downstream_debug_status;
  logic [dbg_w-1:0]                 rx_upstream_debug_status;

  // Loopback corruption
  logic                             corrupt_en;
  logic [lane_sel_w-1:0]            corrupt_lane;
  int                               corrupt_due;

  // Model and phase flags
  logic                             idle_phase;
  logic                             final_check;
  logic                             exp_check;
  logic                             online_set;
  logic [num_lanes-1:0]             strobe_bits;
  logic [num_lanes-1:0]             marker_bits;
  logic [dbg_w-1:0]                 tx_sent_model;
  logic [dbg_w-1:0]                 rx_err_model;
  int                               cycle_count;
  int                               online_cycle;
  integer                           seed;
  model_flit_t                      exp_flit;
  model_flit_t                      model_q [$];

  lpif_txrx_x8_top u_lpif_txrx_x8_top (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  // 100 ns period
  always #50 clk_wr = ~clk_wr;

  // tx_phy back to rx_phy with one lane's strobe dropped on request
  always_comb begin
    rx_phy = tx_phy;
    if (corrupt_en) begin
      rx_phy[corrupt_lane][strobe_pos] = 1'b0;
    end
  end

  // Per-lane control bits
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      strobe_bits[i] = tx_phy[i][strobe_pos];
      marker_bits[i] = tx_phy[i][marker_pos];
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [show_w-1:0] got,
                                 input logic [show_w-1:0] want);
    fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want));
  endtask

  // Drive point just past the rising edge
  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  // Random flit on dstrm plus its model entry
  task automatic drive_flit(input logic valid_bit, input logic corrupt);
    logic [data_w-1:0] data;
    model_flit_t       entry;
    logic              tx_live;
    logic              rx_live;
    for (int w = 0; w < data_w / 32; w++) begin
      data[w*32 +: 32] = $random(seed);
    end
    dstrm_data      = data;
    dstrm_state     = state_w'($random(seed));
    dstrm_protid    = protid_w'($random(seed));
    dstrm_crc       = crc_w'($random(seed));
    dstrm_dvalid    = 1'($random(seed));
    dstrm_crc_valid = 1'($random(seed));
    dstrm_valid     = valid_bit;
    // Strobe drop lands while the flit sits on tx_phy
    corrupt_en = (cycle_count == corrupt_due);
    if (corrupt) begin
      corrupt_due  = cycle_count + 2;
      corrupt_lane = lane_sel_w'({$random(seed)} % num_lanes);
      rx_err_model = rx_err_model + 1'b1;
    end
    // Tx gate seen at the lane register and rx gate at the merger
    tx_live = online_set && (cycle_count >= online_cycle + tx_delay);
    rx_live = online_set && (cycle_count + 2 >= online_cycle + rx_delay);
    if (valid_bit && tx_live) begin
      tx_sent_model = tx_sent_model + 1'b1;
    end
    entry.due       = cycle_count + loop_lat;
    entry.ok        = tx_live && rx_live && !corrupt;
    entry.valid     = valid_bit && entry.ok;
    entry.dvalid    = dstrm_dvalid && entry.ok;
    entry.crc_valid = dstrm_crc_valid && entry.ok;
    entry.state     = dstrm_state;
    entry.protid    = dstrm_protid;
    entry.data      = data;
    entry.crc       = dstrm_crc;
    entry.rx_err    = rx_err_model;
    model_q.push_back(entry);
  endtask

  ////////////////////////////////////////
  // Scoreboard feed and timeout
  ////////////////////////////////////////

  always @(posedge clk_wr) begin
    cycle_count = cycle_count + 1;
    // Expected beat is compared at the following edge
    if (model_q.size() != 0 && model_q[0].due == cycle_count) begin
      exp_flit  <= model_q.pop_front();
      exp_check <= 1'b1;
    end else begin
      exp_check <= 1'b0;
    end
    if (cycle_count >= max_cycles) begin
      fail_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Quiet link before tx goes online
  a_idle_phy: assert property (@(posedge clk_wr) disable iff (!rst_n)
    idle_phase |-> tx_phy == '0)
    else report_mismatch("tx_phy", $sampled(tx_phy), '0);
  a_idle_tx_dbg: assert property (@(posedge clk_wr) disable iff (!rst_n)
    idle_phase |-> tx_downstream_debug_status == '0)
    else report_mismatch("tx_downstream_debug_status", $sampled(tx_downstream_debug_status), '0);
  a_idle_rx_dbg: assert property (@(posedge clk_wr) disable iff (!rst_n)
    idle_phase |-> rx_upstream_debug_status == '0)
    else report_mismatch("rx_upstream_debug_status", $sampled(rx_upstream_debug_status), '0);

  // Strobes rise together exactly on time
  a_strobe_rise: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $rose(tx_online) |-> (strobe_bits == '0) [*strobe_lag] ##1 (strobe_bits == '1))
    else fail_run("Strobe did not rise on every lane exactly on time after tx_online");
  a_marker: assert property (@(posedge clk_wr) disable iff (!rst_n)
    marker_bits == '0)
    else report_mismatch("tx_phy marker bits", $sampled(marker_bits), '0);

  // Qualifiers every cycle
  a_valid: assert property (@(posedge clk_wr) disable iff (!rst_n)
    exp_check |-> ustrm_valid == exp_flit.valid)
    else report_mismatch("ustrm_valid", $sampled(ustrm_valid), $sampled(exp_flit.valid));
  a_dvalid: assert property (@(posedge clk_wr) disable iff (!rst_n)
    exp_check |-> ustrm_dvalid == exp_flit.dvalid)
    else report_mismatch("ustrm_dvalid", $sampled(ustrm_dvalid), $sampled(exp_flit.dvalid));
  a_crc_valid: assert property (@(posedge clk_wr) disable iff (!rst_n)
    exp_check |-> ustrm_crc_valid == exp_flit.crc_valid)
    else report_mismatch("ustrm_crc_valid", $sampled(ustrm_crc_valid),
                         $sampled(exp_flit.crc_valid));

  // Fields only when the flit came through whole
  a_state: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (exp_check && exp_flit.ok) |-> ustrm_state == exp_flit.state)
    else report_mismatch("ustrm_state", $sampled(ustrm_state), $sampled(exp_flit.state));
  a_protid: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (exp_check && exp_flit.ok) |-> ustrm_protid == exp_flit.protid)
    else report_mismatch("ustrm_protid", $sampled(ustrm_protid), $sampled(exp_flit.protid));
  a_data: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (exp_check && exp_flit.ok) |-> ustrm_data == exp_flit.data)
    else report_mismatch("ustrm_data", $sampled(ustrm_data), $sampled(exp_flit.data));
  a_crc: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (exp_check && exp_flit.ok) |-> ustrm_crc == exp_flit.crc)
    else report_mismatch("ustrm_crc", $sampled(ustrm_crc), $sampled(exp_flit.crc));

  // One misalignment per dropped strobe
  a_rx_err: assert property (@(posedge clk_wr) disable iff (!rst_n)
    exp_check |-> rx_upstream_debug_status == exp_flit.rx_err)
    else report_mismatch("rx_upstream_debug_status", $sampled(rx_upstream_debug_status),
                         $sampled(exp_flit.rx_err));
  a_tx_count: assert property (@(posedge clk_wr) disable iff (!rst_n)
    final_check |-> tx_downstream_debug_status == tx_sent_model)
    else report_mismatch("tx_downstream_debug_status", $sampled(tx_downstream_debug_status),
                         $sampled(tx_sent_model));

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    seed            = 32'hc99b_d331;
    clk_wr          = 1'b0;
    rst_n           = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    delay_x_value   = 16'(rx_delay);
    delay_y_value   = 16'(tx_delay);
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = 1'b0;
    dstrm_crc       = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid     = 1'b0;
    corrupt_en      = 1'b0;
    corrupt_lane    = '0;
    corrupt_due     = -1;
    idle_phase      = 1'b0;
    final_check     = 1'b0;
    exp_check       = 1'b0;
    exp_flit        = '0;
    online_set      = 1'b0;
    online_cycle    = 0;
    cycle_count     = 0;
    tx_sent_model   = '0;
    rx_err_model    = '0;
    // Five cycles of reset
    repeat (5) @(posedge clk_wr);
    #1;
    rst_n      = 1'b1;
    idle_phase = 1'b1;
    // Offline traffic must not leak
    repeat (20) begin
      next_cycle();
      drive_flit(1'($random(seed)), 1'b0);
    end
    // Both sides requested online together
    next_cycle();
    idle_phase   = 1'b0;
    tx_online    = 1'b1;
    rx_online    = 1'b1;
    online_set   = 1'b1;
    online_cycle = cycle_count;
    drive_flit(1'b1, 1'b0);
    // Strobes loop back before rx_online_delay rises
    repeat (24) begin
      next_cycle();
      drive_flit(1'b1, 1'b0);
    end
    // Random traffic with both sides online
    repeat (200) begin
      next_cycle();
      drive_flit(1'($random(seed)), 1'b0);
    end
    // Single-lane strobe drops spaced apart
    repeat (4) begin
      next_cycle();
      drive_flit(1'b1, 1'b1);
      repeat (5) begin
        next_cycle();
        drive_flit(1'b1, 1'b0);
      end
    end
    repeat (4) begin
      next_cycle();
      drive_flit(1'b0, 1'b0);
    end
    // Let the last beats reach ustrm
    while (model_q.size() != 0) begin
      next_cycle();
    end
    next_cycle();
    final_check = 1'b1;
    next_cycle();
    final_check = 1'b0;
    next_cycle();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* hw/lpif_txrx_x8_top.sv */
// Top of the eight-lane link layer; connects online sync, codec, slicer, lanes and merger
module lpif_txrx_x8_top
  import lpif_link_pkg::*;
  import lpif_phy_pkg::*;
(
  input  logic                              clk_wr,
  input  logic                              rst_n,
  // Control and configuration
  input  logic                              tx_online,
  input  logic                              rx_online,
  input  logic [15:0]                       delay_x_value,
  input  logic [15:0]                       delay_y_value,
  // PHY side
  output logic [num_lanes-1:0][lane_w-1:0] tx_phy,
  input  logic [num_lanes-1:0][lane_w-1:0] rx_phy,
  // Downstream channel
  input  logic [state_w-1:0]                dstrm_state,
  input  logic [protid_w-1:0]               dstrm_protid,
  input  logic [data_w-1:0]                 dstrm_data,
  input  logic                              dstrm_dvalid,
  input  logic [crc_w-1:0]                  dstrm_crc,
  input  logic                              dstrm_crc_valid,
  input  logic                              dstrm_valid,
  // Upstream channel
  output logic [state_w-1:0]                ustrm_state,
  output logic [protid_w-1:0]               ustrm_protid,
  output logic [data_w-1:0]                 ustrm_data,
  output logic                              ustrm_dvalid,
  output logic [crc_w-1:0]                  ustrm_crc,
  output logic                              ustrm_crc_valid,
  output logic                              ustrm_valid,
  // Debug status
  output logic [dbg_w-1:0]                  tx_downstream_debug_status,
  output logic [dbg_w-1:0]                  rx_upstream_debug_status
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  logic                                     tx_online_delay;
  logic                                     rx_online_delay;
  logic [flit_w-1:0]                        tx_flit;
  logic [flit_w-1:0]                        rx_flit;
  logic                                     rx_flit_ok;
  logic [num_lanes-1:0][lane_payload_w-1:0] lane_tx_payload;
  logic [num_lanes-1:0][lane_payload_w-1:0] lane_rx_payload;
  logic [num_lanes-1:0]                     lane_strobe;

  // Online delays
  lpif_online_sync u_online_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  // User fields to and from flit words
  lpif_flit_codec u_flit_codec (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .rx_flit         (rx_flit),
    .rx_flit_ok      (rx_flit_ok),
    .tx_flit         (tx_flit),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  ////////////////////////////////////////
  // Lane side
  ////////////////////////////////////////

  lpif_lane_slicer u_lane_slicer (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_flit                    (tx_flit),
    .tx_online_delay            (tx_online_delay),
    .lane_tx_payload            (lane_tx_payload),
    .tx_downstream_debug_status (tx_downstream_debug_status)
  );

  // One lane block per PHY lane
  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    lpif_phy_lane u_phy_lane (
      .clk_wr          (clk_wr),
      .rst_n           (rst_n),
      .lane_tx_payload (lane_tx_payload[i]),
      .tx_online_delay (tx_online_delay),
      .rx_phy          (rx_phy[i]),
      .tx_phy          (tx_phy[i]),
      .lane_rx_payload (lane_rx_payload[i]),
      .lane_strobe     (lane_strobe[i])
    );
  end

  lpif_lane_merger u_lane_merger (
    .clk_wr                   (clk_wr),
    .rst_n                    (rst_n),
    .lane_rx_payload          (lane_rx_payload),
    .lane_strobe              (lane_strobe),
    .rx_online_delay          (rx_online_delay),
    .rx_flit                  (rx_flit),
    .rx_flit_ok               (rx_flit_ok),
    .rx_upstream_debug_status (rx_upstream_debug_status)
  );

endmodule

/* hw/lpif_lane_merger.sv */
// Joins lane payloads into the receive flit, checks lane alignment, counts misalignment
module lpif_lane_merger
  import lpif_link_pkg::*;
  import lpif_phy_pkg::*;
(
  input  logic                                      clk_wr,
  input  logic                                      rst_n,
  input  logic [num_lanes-1:0][lane_payload_w-1:0] lane_rx_payload,
  input  logic [num_lanes-1:0]                      lane_strobe,
  input  logic                                      rx_online_delay,
  output logic [flit_w-1:0]                         rx_flit,
  output logic                                      rx_flit_ok,
  output logic [dbg_w-1:0]                          rx_upstream_debug_status
);

  ////////////////////////////////////////
  // Alignment check
  ////////////////////////////////////////

  logic [num_lanes*lane_payload_w-1:0] merged;
  logic                                strobe_all;
  logic                                strobe_misalign;

  // Lane 0 lowest, padding on top is dropped
  assign merged          = lane_rx_payload;
  assign strobe_all      = &lane_strobe;
  // Some lanes strobed, others not
  assign strobe_misalign = (|lane_strobe) & ~strobe_all;

  ////////////////////////////////////////
  // Merge register
  ////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    rx_flit <= merged[flit_w-1:0];
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_flit_ok <= 1'b0;
    end else begin
      rx_flit_ok <= strobe_all & rx_online_delay;
    end
  end

  // Misalignment count, saturating
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_upstream_debug_status <= '0;
    end else if (strobe_misalign && (rx_upstream_debug_status != '1)) begin
      rx_upstream_debug_status <= rx_upstream_debug_status + 1'b1;
    end
  end

  // A good flit needs the receive side online one cycle earlier
  a_ok_online: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_flit_ok |-> $past(rx_online_delay));

endmodule

/* hw/lpif_phy_lane.sv */
// One PHY lane: adds strobe and marker on transmit, strips and flags them on receive
module lpif_phy_lane
  import lpif_phy_pkg::*;
(
  input  logic                      clk_wr,
  input  logic                      rst_n,
  input  logic [lane_payload_w-1:0] lane_tx_payload,
  input  logic                      tx_online_delay,
  input  logic [lane_w-1:0]         rx_phy,
  output logic [lane_w-1:0]         tx_phy,
  output logic [lane_payload_w-1:0] lane_rx_payload,
  output logic                      lane_strobe
);

  ////////////////////////////////////////
  // Transmit word
  ////////////////////////////////////////

  logic [lane_w-1:0] tx_word;

  always_comb begin
    tx_word                         = '0;
    tx_word[lane_payload_w-1:0]     = lane_tx_payload;
    // No user marker
    tx_word[marker_pos]             = 1'b0;
    // Strobe tracks link online
    tx_word[strobe_pos]             = tx_online_delay;
  end

  // Lane output register
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_word;
    end
  end

  ////////////////////////////////////////
  // Receive strip
  ////////////////////////////////////////

  // Payload, no reset
  always_ff @(posedge clk_wr) begin
    lane_rx_payload <= rx_phy[lane_payload_w-1:0];
  end

  // Strobe presence
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      lane_strobe <= 1'b0;
    end else begin
      lane_strobe <= rx_phy[strobe_pos];
    end
  end

  // Marker never leaves the lane
  a_no_marker: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_phy[marker_pos]);

endmodule

/* hw/lpif_lane_slicer.sv */
// Cuts the transmit flit into per-lane payloads and counts flits sent while online
module lpif_lane_slicer
  import lpif_link_pkg::*;
  import lpif_phy_pkg::*;
(
  input  logic                                      clk_wr,
  input  logic                                      rst_n,
  input  logic [flit_w-1:0]                         tx_flit,
  input  logic                                      tx_online_delay,
  output logic [num_lanes-1:0][lane_payload_w-1:0] lane_tx_payload,
  output logic [dbg_w-1:0]                          tx_downstream_debug_status
);

  ////////////////////////////////////////
  // Slice
  ////////////////////////////////////////

  // Flit zero-extended to the full lane span
  logic [num_lanes*lane_payload_w-1:0] flit_padded;

  assign flit_padded = (num_lanes*lane_payload_w)'(tx_flit);

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      // Lane i takes the next 38 bits, quiet when offline
      if (tx_online_delay) begin
        lane_tx_payload[i] = flit_padded[i*lane_payload_w +: lane_payload_w];
      end else begin
        lane_tx_payload[i] = '0;
      end
    end
  end

  ////////////////////////////////////////
  // Sent-flit counter
  ////////////////////////////////////////

  // Saturates at all ones
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_downstream_debug_status <= '0;
    end else if (tx_online_delay && tx_flit[valid_pos] &&
                 (tx_downstream_debug_status != '1)) begin
      tx_downstream_debug_status <= tx_downstream_debug_status + 1'b1;
    end
  end

endmodule

/* hw/lpif_flit_codec.sv */
// Packs downstream fields into the registered flit word and unpacks received words upstream
module lpif_flit_codec
  import lpif_link_pkg::*;
(
  input  logic                clk_wr,
  input  logic                rst_n,
  // Downstream user fields
  input  logic [state_w-1:0]  dstrm_state,
  input  logic [protid_w-1:0] dstrm_protid,
  input  logic [data_w-1:0]   dstrm_data,
  input  logic                dstrm_dvalid,
  input  logic [crc_w-1:0]    dstrm_crc,
  input  logic                dstrm_crc_valid,
  input  logic                dstrm_valid,
  // Merged receive word
  input  logic [flit_w-1:0]   rx_flit,
  input  logic                rx_flit_ok,
  output logic [flit_w-1:0]   tx_flit,
  // Upstream user fields
  output logic [state_w-1:0]  ustrm_state,
  output logic [protid_w-1:0] ustrm_protid,
  output logic [data_w-1:0]   ustrm_data,
  output logic                ustrm_dvalid,
  output logic [crc_w-1:0]    ustrm_crc,
  output logic                ustrm_crc_valid,
  output logic                ustrm_valid
);

  ////////////////////////////////////////
  // Transmit pack
  ////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    // Payload fields without reset
    tx_flit[crc_lsb +: crc_w]       <= dstrm_crc;
    tx_flit[data_lsb +: data_w]     <= dstrm_data;
    tx_flit[protid_lsb +: protid_w] <= dstrm_protid;
    tx_flit[state_lsb +: state_w]   <= dstrm_state;
    // Qualifier bits
    if (!rst_n) begin
      tx_flit[valid_pos]     <= 1'b0;
      tx_flit[crc_valid_pos] <= 1'b0;
      tx_flit[dvalid_pos]    <= 1'b0;
    end else begin
      tx_flit[valid_pos]     <= dstrm_valid;
      tx_flit[crc_valid_pos] <= dstrm_crc_valid;
      tx_flit[dvalid_pos]    <= dstrm_dvalid;
    end
  end

  ////////////////////////////////////////
  // Receive unpack
  ////////////////////////////////////////

  // Fields as received
  assign ustrm_state     = rx_flit[state_lsb +: state_w];
  assign ustrm_protid    = rx_flit[protid_lsb +: protid_w];
  assign ustrm_data      = rx_flit[data_lsb +: data_w];
  assign ustrm_crc       = rx_flit[crc_lsb +: crc_w];

  // Qualifiers gated by lane alignment
  assign ustrm_valid     = rx_flit[valid_pos] & rx_flit_ok;
  assign ustrm_dvalid    = rx_flit[dvalid_pos] & rx_flit_ok;
  assign ustrm_crc_valid = rx_flit[crc_valid_pos] & rx_flit_ok;

endmodule

/* hw/lpif_online_sync.sv */
// Delays tx_online and rx_online by programmable cycle counts; feeds the lane-side blocks
module lpif_online_sync (
  input  logic        clk_wr,
  input  logic        rst_n,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  output logic        tx_online_delay,
  output logic        rx_online_delay
);

  ////////////////////////////////////////
  // Channel 0 is transmit, channel 1 receive
  ////////////////////////////////////////

  logic [1:0]  online_in;
  logic [1:0]  online_q;
  logic [1:0]  online_out;
  logic [15:0] delay_val [2];
  logic [15:0] cnt       [2];

  assign online_in    = {rx_online, tx_online};
  // Y delay for transmit, X delay for receive
  assign delay_val[0] = delay_y_value;
  assign delay_val[1] = delay_x_value;

  ////////////////////////////////////////
  // Down-counters
  ////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      online_q   <= '0;
      online_out <= '0;
      for (int ch = 0; ch < 2; ch++) begin
        cnt[ch] <= '0;
      end
    end else begin
      // Edge detect on the raw inputs
      online_q <= online_in;
      for (int ch = 0; ch < 2; ch++) begin
        if (!online_in[ch]) begin
          // Drop at once
          online_out[ch] <= 1'b0;
          cnt[ch]        <= '0;
        end else if (!online_q[ch]) begin
          // Rise seen, load the delay; zero goes high right away
          cnt[ch]        <= delay_val[ch];
          online_out[ch] <= (delay_val[ch] == 16'd0);
        end else if (!online_out[ch]) begin
          // Count down, release on the last step
          if (cnt[ch] > 16'd1) begin
            cnt[ch] <= cnt[ch] - 16'd1;
          end else begin
            online_out[ch] <= 1'b1;
          end
        end
      end
    end
  end

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

  // Delayed online only ever follows a sampled high input
  a_tx_follows: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_online_delay |-> $past(tx_online));
  a_rx_follows: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_online_delay |-> $past(rx_online));

endmodule

/* hw/lpif_phy_pkg.sv */
// Lane count, PHY word shape and debug width; imported by the lane-side modules and top
package lpif_phy_pkg;

  ////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////

  // Eight PHY lanes on one clock
  localparam int unsigned num_lanes      = 8;

  // Raw PHY word per lane
  localparam int unsigned lane_w         = 40;

  // Flit bits per lane, 8 x 38 = 304 covers the 273-bit flit
  localparam int unsigned lane_payload_w = 38;

  ////////////////////////////////////////
  // Per-lane control bits
  ////////////////////////////////////////

  // Strobe marks a live word, top bit
  localparam int unsigned strobe_pos     = 39;

  // Marker just below strobe, held at zero
  localparam int unsigned marker_pos     = 38;

  // Debug status word width
  localparam int unsigned dbg_w          = 32;

endpackage

/* hw/lpif_link_pkg.sv */
// Link-layer field widths and flit bit layout; imported by the codec, slicer, merger and top
package lpif_link_pkg;

  ////////////////////////////////////////
  // User field widths
  ////////////////////////////////////////

  // Link state and protocol id
  localparam int unsigned state_w  = 4;
  localparam int unsigned protid_w = 2;

  // Flit payload and its check bits
  localparam int unsigned data_w   = 256;
  localparam int unsigned crc_w    = 8;

  // Packed word: the fields above plus valid, dvalid and crc_valid
  localparam int unsigned flit_w   = state_w + protid_w + data_w + crc_w + 3;

  ////////////////////////////////////////
  // Flit word layout, bit 0 upward
  ////////////////////////////////////////

  // Flit valid sits in the lowest bit
  localparam int unsigned valid_pos     = 0;
  localparam int unsigned crc_valid_pos = valid_pos + 1;

  // CRC field
  localparam int unsigned crc_lsb       = crc_valid_pos + 1;
  localparam int unsigned dvalid_pos    = crc_lsb + crc_w;

  // Data field
  localparam int unsigned data_lsb      = dvalid_pos + 1;

  // Protocol id then link state at the top
  localparam int unsigned protid_lsb    = data_lsb + data_w;
  localparam int unsigned state_lsb     = protid_lsb + protid_w;

endpackage
